/* wb_pipe.f */
+incdir+logic
logic/wb_pipe_pkg.sv
logic/wb_mem_pkg.sv
logic/wb_lsu.sv
logic/wb_copro.sv
logic/wb_stage.sv
logic/wb_regfile.sv
logic/wb_pipe_top.sv
test/wb_pipe_tb.sv

/* Makefile */
# Verilator build and run for the write-back subsystem

VERILATOR ?= verilator
TOP       ?= wb_pipe_tb
BUILD_DIR ?= build
SEED_ARGS ?= +verilator+seed+73
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

FILELIST  := wb_pipe.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* test/wb_pipe_tb.sv */
/*
  Testbench for the write-back subsystem, one instruction in flight with an idle gap after it
  Expected flags and the register model are driven next to the stimulus, assertions compare
  Loads only read words that were stored earlier in the run
*/
`timescale 1ns/1ps
`default_nettype none

`include "wb_pipe_macros.svh"

module wb_pipe_tb;

  localparam int UNIT_NONE = 0;
  localparam int UNIT_LSU  = 1;
  localparam int UNIT_XIF  = 2;
  // Longest wait for one instruction, with margin
  localparam int WAIT_LIMIT = `WB_COPRO_MAX_LAT + `WB_LSU_LATENCY + 2;
  // About 200 instructions at up to 6 cycles each, plus margin
  localparam int CYCLE_LIMIT = 4000;

  logic                     clk;
  logic                     rst_n;
  wb_pipe_pkg::ex_wb_pipe_t pipe;
  wb_pipe_pkg::ctrl_fsm_t   ctrl;
  wb_pipe_pkg::rf_addr_t    raddr;
  logic [`WB_XLEN-1:0]      rdata;
  logic                     wb_valid;
  logic                     wb_ready;
  logic                     data_stall;

  // Reference state
  logic                     exp_valid;
  logic                     exp_ready;
  logic                     exp_stall;
  logic [`WB_XLEN-1:0]      model [32];
  logic [`WB_XLEN-1:0]      mem_model [`WB_MPU_LIMIT / 4];
  logic [`WB_XLEN-1:0]      exp_rdata;
  int                       cycle_cnt = 0;

  wb_pipe_top dut0 (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .ex_wb_pipe_i (pipe),
    .ctrl_fsm_i   (ctrl),
    .rf_raddr_i   (raddr),
    .rf_rdata_o   (rdata),
    .wb_valid_o   (wb_valid),
    .wb_ready_o   (wb_ready),
    .data_stall_o (data_stall)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign exp_rdata = model[raddr];

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("CHECK FAILED %s: got %h expected %h", name, got, want);
    abort_run();
  endtask

  // Hard stop if the run hangs
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_valid)
    else report_mismatch("wb_valid_o", 32'($sampled(wb_valid)), 32'($sampled(exp_valid)));

  a_wb_ready: assert property (@(posedge clk) disable iff (!rst_n) wb_ready == exp_ready)
    else report_mismatch("wb_ready_o", 32'($sampled(wb_ready)), 32'($sampled(exp_ready)));

  a_stall: assert property (@(posedge clk) disable iff (!rst_n) data_stall == exp_stall)
    else report_mismatch("data_stall_o", 32'($sampled(data_stall)), 32'($sampled(exp_stall)));

  a_rdata: assert property (@(posedge clk) disable iff (!rst_n) rdata == exp_rdata)
    else report_mismatch("rf_rdata_o", $sampled(rdata), $sampled(exp_rdata));

  // x0 reads zero whatever was written to it
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (raddr == '0) |-> (rdata == '0))
    else report_mismatch("rf_rdata_o x0", $sampled(rdata), 32'h0);

  ////////////////////////////////////////
  // Reference functions and builders
  ////////////////////////////////////////

  function automatic logic [31:0] byte_swap(input logic [31:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
  endfunction

  // Clears the lowest set bit until none is left
  function automatic logic [31:0] count_ones(input logic [31:0] v);
    logic [31:0] x;
    logic [31:0] n;
    x = v;
    n = '0;
    while (x != '0) begin
      x = x & (x - 32'd1);
      n = n + 32'd1;
    end
    return n;
  endfunction

  function automatic wb_pipe_pkg::ex_wb_pipe_t alu_instr(input wb_pipe_pkg::rf_addr_t waddr,
                                                        input logic we,
                                                        input logic [31:0] data);
    wb_pipe_pkg::ex_wb_pipe_t p;
    p             = '0;
    p.instr_valid = 1'b1;
    p.rf_we       = we;
    p.rf_waddr    = waddr;
    p.rf_wdata    = data;
    return p;
  endfunction

  // Loads write the destination, stores write nothing
  function automatic wb_pipe_pkg::ex_wb_pipe_t lsu_instr(input wb_pipe_pkg::rf_addr_t waddr,
                                                        input logic store,
                                                        input logic [31:0] addr,
                                                        input logic [31:0] wdata);
    wb_pipe_pkg::ex_wb_pipe_t p;
    p             = '0;
    p.instr_valid = 1'b1;
    p.rf_we       = !store;
    p.rf_waddr    = waddr;
    p.lsu_en      = 1'b1;
    p.lsu_we      = store;
    p.lsu_addr    = addr;
    p.lsu_wdata   = wdata;
    return p;
  endfunction

  function automatic wb_pipe_pkg::ex_wb_pipe_t xif_instr(input wb_pipe_pkg::rf_addr_t waddr,
                                                        input logic [1:0] funct,
                                                        input logic [31:0] operand);
    wb_pipe_pkg::ex_wb_pipe_t p;
    p             = '0;
    p.instr_valid = 1'b1;
    p.rf_we       = 1'b1;
    p.rf_waddr    = waddr;
    p.xif_en      = 1'b1;
    p.xif_funct   = funct;
    p.xif_operand = operand;
    return p;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Flags for cycle cyc of an instruction that retires in cycle lat
  task automatic expect_cycle(input int unit, input int lat, input int cyc, input logic blocked);
    exp_valid <= (cyc == lat) && !blocked;
    exp_stall <= (unit == UNIT_LSU) && (cyc < lat);
    // LSU is busy between its start cycle and data return
    exp_ready <= !((unit == UNIT_XIF) && (cyc < lat)) &&
                 !((unit == UNIT_LSU) && (cyc >= 1) && (cyc < lat));
  endtask

  // Present one instruction, wait for wb_valid_o or a kill, then go idle
  task automatic retire(input wb_pipe_pkg::ex_wb_pipe_t instr, input wb_pipe_pkg::ctrl_fsm_t ctl,
                        input int unit, input int lat, input logic [31:0] result,
                        input logic writes);
    int   cyc;
    logic done;
    logic blocked;
    cyc     = 0;
    done    = 1'b0;
    blocked = ctl.kill_wb || ctl.halt_wb;
    @(posedge clk);
    pipe  <= instr;
    ctrl  <= ctl;
    raddr <= instr.rf_waddr;
    expect_cycle(unit, lat, cyc, blocked);
    while (!done) begin
      @(negedge clk);
      if (wb_valid || blocked) begin
        done = 1'b1;
      end else if (cyc >= WAIT_LIMIT) begin
        $display("Timeout: wb_valid_o never rose for the instruction to x%0d", instr.rf_waddr);
        abort_run();
      end
      @(posedge clk);
      if (!done) begin
        cyc = cyc + 1;
        expect_cycle(unit, lat, cyc, blocked);
      end
    end
    // Register file takes the result on this edge
    if (writes && !blocked && (instr.rf_waddr != '0)) begin
      model[instr.rf_waddr] <= result;
    end
    pipe      <= '0;
    ctrl      <= '0;
    exp_valid <= 1'b0;
    exp_stall <= 1'b0;
    exp_ready <= 1'b1;
  endtask

  initial begin
    wb_pipe_pkg::ctrl_fsm_t   ctl;
    wb_pipe_pkg::rf_addr_t    waddr;
    logic [31:0]              data;
    logic [31:0]              addr;
    logic [1:0]               funct;
    logic                     we;
    int                       w;
    void'($urandom(73));
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    ctl       = '0;
    rst_n     <= 1'b0;
    pipe      <= '0;
    ctrl      <= '0;
    raddr     <= '0;
    exp_valid <= 1'b0;
    exp_ready <= 1'b1;
    exp_stall <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // ALU writes, x0 included, some with rf_we low
    for (int n = 0; n < 60; n++) begin
      waddr = 5'($urandom % 32);
      data  = $urandom;
      we    = ($urandom % 4) != 0;
      retire(alu_instr(waddr, we, data), ctl, UNIT_NONE, 0, data, we);
    end

    // Fill the legal region, then load it back in random order
    for (int n = 0; n < `WB_MPU_LIMIT / 4; n++) begin
      data         = $urandom;
      mem_model[n] = data;
      retire(lsu_instr('0, 1'b1, 32'(n * 4), data), ctl, UNIT_LSU, `WB_LSU_LATENCY, '0, 1'b0);
    end
    for (int n = 0; n < 32; n++) begin
      w     = int'($urandom % (`WB_MPU_LIMIT / 4));
      waddr = 5'(1 + ($urandom % 31));
      retire(lsu_instr(waddr, 1'b0, 32'(w * 4), '0), ctl, UNIT_LSU, `WB_LSU_LATENCY,
             mem_model[w], 1'b1);
    end

    // MPU faults retire at once and leave the destination alone
    for (int n = 0; n < 10; n++) begin
      addr  = 32'(`WB_MPU_LIMIT) + 32'(($urandom % 256) * 4);
      waddr = 5'(1 + ($urandom % 31));
      retire(lsu_instr(waddr, n[0], addr, $urandom), ctl, UNIT_LSU, 0, '0, 1'b0);
    end

    // Coprocessor byte swap and popcount
    for (int n = 0; n < 40; n++) begin
      funct = 2'($urandom % 2);
      data  = $urandom;
      waddr = 5'($urandom % 32);
      retire(xif_instr(waddr, funct, data), ctl, UNIT_XIF, int'(data[1:0]) + 1,
             (funct == 2'd0) ? byte_swap(data) : count_ones(data), 1'b1);
    end
    // Illegal functions complete with no write
    for (int n = 0; n < 6; n++) begin
      funct = 2'd2 + 2'($urandom % 2);
      data  = $urandom;
      waddr = 5'(1 + ($urandom % 31));
      retire(xif_instr(waddr, funct, data), ctl, UNIT_XIF, int'(data[1:0]) + 1, '0, 1'b0);
    end

    // Kill and halt on ALU instructions
    for (int n = 0; n < 10; n++) begin
      ctl.kill_wb = n[0];
      ctl.halt_wb = !n[0];
      waddr       = 5'(1 + ($urandom % 31));
      data        = $urandom;
      retire(alu_instr(waddr, 1'b1, data), ctl, UNIT_NONE, 0, data, 1'b1);
    end

    // Sweep the read port over every register
    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      raddr <= 5'(r);
    end
    repeat (2) @(posedge clk);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/wb_pipe_top.sv */
/*
  Write-back subsystem top with stage, LSU, coprocessor and register file
  The environment holds ex_wb_pipe_i until wb_valid_o or a kill
*/
`timescale 1ns/1ps
`default_nettype none

`include "wb_pipe_macros.svh"

module wb_pipe_top (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  wb_pipe_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  wb_pipe_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  wb_pipe_pkg::rf_addr_t    rf_raddr_i,
  output logic [`WB_XLEN-1:0]      rf_rdata_o,
  output logic                     wb_valid_o,
  output logic                     wb_ready_o,
  output logic                     data_stall_o
);

  // Stage to LSU
  logic                    lsu_req;
  logic                    lsu_valid;
  logic                    lsu_ready;
  logic [`WB_XLEN-1:0]     lsu_rdata;
  wb_mem_pkg::mpu_status_e lsu_mpu_status;

  // Stage to coprocessor
  logic                    xif_issue;
  logic                    xif_valid;
  wb_mem_pkg::xif_result_t xif_result;

  // Stage to register file
  logic                    rf_we;
  wb_pipe_pkg::rf_addr_t   rf_waddr;
  logic [`WB_XLEN-1:0]     rf_wdata;

  wb_stage stage0 (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .ex_wb_pipe_i       (ex_wb_pipe_i),
    .ctrl_fsm_i         (ctrl_fsm_i),
    .lsu_rdata_i        (lsu_rdata),
    .lsu_mpu_status_i   (lsu_mpu_status),
    .lsu_valid_i        (lsu_valid),
    .lsu_ready_i        (lsu_ready),
    .lsu_valid_o        (lsu_req),
    .xif_result_i       (xif_result),
    .xif_result_valid_i (xif_valid),
    .xif_result_ready_o (xif_issue),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .wb_valid_o         (wb_valid_o),
    .wb_ready_o         (wb_ready_o),
    .data_stall_o       (data_stall_o)
  );

  // Request fields come straight from the held pipe register
  wb_lsu lsu0 (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .lsu_valid_i      (lsu_req),
    .lsu_we_i         (ex_wb_pipe_i.lsu_we),
    .lsu_addr_i       (ex_wb_pipe_i.lsu_addr),
    .lsu_wdata_i      (ex_wb_pipe_i.lsu_wdata),
    .lsu_valid_o      (lsu_valid),
    .lsu_ready_o      (lsu_ready),
    .lsu_rdata_o      (lsu_rdata),
    .lsu_mpu_status_o (lsu_mpu_status)
  );

  // Result ready doubles as the issue level
  wb_copro copro0 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (xif_issue),
    .funct_i        (wb_mem_pkg::xif_funct_e'(ex_wb_pipe_i.xif_funct)),
    .operand_i      (ex_wb_pipe_i.xif_operand),
    .result_ready_i (xif_issue),
    .result_valid_o (xif_valid),
    .result_o       (xif_result)
  );

  wb_regfile regfile0 (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

`default_nettype wire

/* logic/wb_regfile.sv */
/*
  32-entry register file, one write port and one combinational read port
  x0 is hardwired to zero, and all entries clear on reset
*/
`timescale 1ns/1ps
`default_nettype none

`include "wb_pipe_macros.svh"

module wb_regfile (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  we_i,
  input  wb_pipe_pkg::rf_addr_t waddr_i,
  input  logic [`WB_XLEN-1:0]   wdata_i,
  input  wb_pipe_pkg::rf_addr_t raddr_i,
  output logic [`WB_XLEN-1:0]   rdata_o
);

  // One entry per register index
  localparam int NUM_REGS = 2 ** $bits(wb_pipe_pkg::rf_addr_t);

  logic [`WB_XLEN-1:0] regs_q [NUM_REGS];
  logic                write_en;

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Writes to x0 are dropped, so entry 0 keeps its reset value
  assign write_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (write_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // No bypass, a write shows up after the edge
  assign rdata_o = regs_q[raddr_i];

endmodule

`default_nettype wire

/* logic/wb_stage.sv */
/*
  Write-back stage, picks the result and gates the register file write
  Nothing sits downstream, so results are taken as soon as they arrive
*/
`timescale 1ns/1ps
`default_nettype none

`include "wb_pipe_macros.svh"

module wb_stage (
  input  logic                     clk,       // Assertions only
  input  logic                     rst_n_i,   // Assertions only

  // EX/WB pipe and controller
  input  wb_pipe_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  wb_pipe_pkg::ctrl_fsm_t   ctrl_fsm_i,

  // LSU
  input  logic [`WB_XLEN-1:0]      lsu_rdata_i,
  input  wb_mem_pkg::mpu_status_e  lsu_mpu_status_i,
  input  logic                     lsu_valid_i,
  input  logic                     lsu_ready_i,
  output logic                     lsu_valid_o,

  // Coprocessor result
  input  wb_mem_pkg::xif_result_t  xif_result_i,
  input  logic                     xif_result_valid_i,
  output logic                     xif_result_ready_o,

  // Register file write port
  output logic                     rf_we_o,
  output wb_pipe_pkg::rf_addr_t    rf_waddr_o,
  output logic [`WB_XLEN-1:0]      rf_wdata_o,

  // Stage status
  output logic                     wb_valid_o,
  output logic                     wb_ready_o,
  output logic                     data_stall_o
);

  logic instr_present;
  logic instr_valid;
  logic lsu_exception;
  logic xif_active;
  logic xif_waiting;
  logic xif_exception;
  logic wb_valid;

  // Raw valid from EX, then gated by the controller
  assign instr_present = ex_wb_pipe_i.instr_valid;
  assign instr_valid   = instr_present && !ctrl_fsm_i.kill_wb && !ctrl_fsm_i.halt_wb;

  assign lsu_exception = ex_wb_pipe_i.lsu_en &&
                         (lsu_mpu_status_i != wb_mem_pkg::MPU_OK);

  ////////////////////////////////////////
  // Coprocessor result
  ////////////////////////////////////////

  assign xif_active         = instr_present && ex_wb_pipe_i.xif_en;
  assign xif_waiting        = xif_active && !xif_result_valid_i;
  assign xif_exception      = xif_active && xif_result_valid_i && xif_result_i.exc;
  // Take the result as soon as the offload reaches WB
  assign xif_result_ready_o = xif_active;

  ////////////////////////////////////////
  // LSU handshake
  ////////////////////////////////////////

  // Not gated by kill or halt, an access in flight must run to completion
  assign lsu_valid_o = instr_present && ex_wb_pipe_i.lsu_en;

  ////////////////////////////////////////
  // Valid, ready and stall
  ////////////////////////////////////////

  // Plain instructions retire now unless waiting on the coprocessor
  // LSU instructions retire on data return or on an MPU fault
  assign wb_valid = instr_valid &&
                    ((!ex_wb_pipe_i.lsu_en && !xif_waiting) ||
                     (ex_wb_pipe_i.lsu_en && (lsu_valid_i || lsu_exception)));

  assign wb_valid_o   = wb_valid;
  assign wb_ready_o   = lsu_ready_i && !xif_waiting;
  assign data_stall_o = instr_present && ex_wb_pipe_i.lsu_en && !lsu_valid_i && !wb_valid;

  ////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////

  // Write only when the result is final, so stale load data never lands
  assign rf_we_o    = ex_wb_pipe_i.rf_we && wb_valid && !lsu_exception && !xif_exception;
  assign rf_waddr_o = ex_wb_pipe_i.rf_waddr;

  always_comb begin
    if (ex_wb_pipe_i.lsu_en) begin
      rf_wdata_o = lsu_rdata_i;
    end else if (ex_wb_pipe_i.xif_en) begin
      rf_wdata_o = xif_result_i.data;
    end else begin
      rf_wdata_o = ex_wb_pipe_i.rf_wdata;
    end
  end

  // One result source per instruction
  a_one_unit: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_present |-> !(ex_wb_pipe_i.lsu_en && ex_wb_pipe_i.xif_en))
    else $error("wb_stage lsu_en and xif_en both set");

  // A legal access in flight in the LSU must not be dropped
  a_lsu_no_kill: assert property (@(posedge clk) disable iff (!rst_n_i)
    (lsu_valid_o && !lsu_valid_i && !lsu_exception) |-> !ctrl_fsm_i.kill_wb)
    else $error("wb_stage kill during pending load/store");

endmodule

`default_nettype wire

/* logic/wb_copro.sv */
/*
  Offload coprocessor, latency is operand[1:0] plus 1 cycles
  Issue is a level, after a handshake a still high issue starts the next operation
*/
`timescale 1ns/1ps
`default_nettype none

`include "wb_pipe_macros.svh"

module wb_copro (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    issue_valid_i,
  input  wb_mem_pkg::xif_funct_e  funct_i,
  input  logic [`WB_XLEN-1:0]     operand_i,
  input  logic                    result_ready_i,
  output logic                    result_valid_o,
  output wb_mem_pkg::xif_result_t result_o
);

  localparam int CNT_W = $clog2(`WB_COPRO_MAX_LAT);

  wb_mem_pkg::xif_result_t result_d;
  wb_mem_pkg::xif_result_t result_q;
  logic [CNT_W-1:0]        cnt_q;
  logic                    busy_q;
  logic                    valid_q;
  logic                    start;
  logic                    lat_zero;
  logic                    finish;
  logic                    load_result;

  function automatic logic [`WB_XLEN-1:0] popcount(input logic [`WB_XLEN-1:0] v);
    logic [`WB_XLEN-1:0] n;
    n = '0;
    for (int i = 0; i < `WB_XLEN; i++) begin
      n = n + `WB_XLEN'(v[i]);
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // Function units
  ////////////////////////////////////////

  always_comb begin
    result_d.data = '0;
    result_d.exc  = 1'b0;
    case (funct_i)
      wb_mem_pkg::XIF_BSWAP: begin
        // Reverse byte order
        for (int b = 0; b < `WB_XLEN / 8; b++) begin
          result_d.data[8*b +: 8] = operand_i[`WB_XLEN-8-8*b +: 8];
        end
      end
      wb_mem_pkg::XIF_POPCNT: result_d.data = popcount(operand_i);
      default:                result_d.exc  = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Countdown and result handshake
  ////////////////////////////////////////

  assign start       = issue_valid_i && !busy_q && !valid_q;
  assign lat_zero    = (operand_i[1:0] == 2'b00);
  assign finish      = busy_q && (cnt_q == '0);
  assign load_result = (start && lat_zero) || finish;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (start) begin
      if (lat_zero) begin
        valid_q <= 1'b1;
      end else begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(operand_i[1:0] - 2'd1);
      end
    end else if (finish) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b1;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (valid_q && result_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Operand is held by the pipe, so compute at the end
  always_ff @(posedge clk) begin
    if (load_result) begin
      result_q <= result_d;
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;

  a_result_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o)))
    else $error("wb_copro result changed before handshake");

endmodule

`default_nettype wire

/* logic/wb_lsu.sv */
/*
  Load/store unit with a private word memory and a fixed latency
  Accesses must be word aligned and held until completion, and valid pulses for one cycle
  An access outside the MPU region faults at once and never touches memory
*/
`timescale 1ns/1ps
`default_nettype none

`include "wb_pipe_macros.svh"

module wb_lsu (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    lsu_valid_i,
  input  logic                    lsu_we_i,
  input  logic [`WB_XLEN-1:0]     lsu_addr_i,
  input  logic [`WB_XLEN-1:0]     lsu_wdata_i,
  output logic                    lsu_valid_o,
  output logic                    lsu_ready_o,
  output logic [`WB_XLEN-1:0]     lsu_rdata_o,
  output wb_mem_pkg::mpu_status_e lsu_mpu_status_o
);

  localparam int CNT_W = $clog2(`WB_LSU_LATENCY);
  localparam int IDX_W = $clog2(`WB_MEM_WORDS);

  logic [`WB_XLEN-1:0] mem_q [`WB_MEM_WORDS];
  logic [`WB_XLEN-1:0] rdata_q;
  logic [CNT_W-1:0]    cnt_q;
  logic                busy_q;
  logic                done_q;
  logic                legal;
  logic                start;
  logic                finish;
  logic [IDX_W-1:0]    word_idx;

  ////////////////////////////////////////
  // MPU region check
  ////////////////////////////////////////

  assign legal = (lsu_addr_i < `WB_XLEN'(`WB_MPU_LIMIT));

  // Combinational so a fault retires in the presentation cycle
  assign lsu_mpu_status_o = (lsu_valid_i && !legal) ? wb_mem_pkg::MPU_RE_FAULT
                                                    : wb_mem_pkg::MPU_OK;

  ////////////////////////////////////////
  // Latency control
  ////////////////////////////////////////

  // No new start in the completion cycle, the request there is the same one
  assign start    = lsu_valid_i && legal && !busy_q && !done_q;
  assign finish   = busy_q && (cnt_q == '0);
  assign word_idx = lsu_addr_i[IDX_W+1:2];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= finish;
      if (start) begin
        busy_q <= 1'b1;
        // Start cycle and completion edge take two of the cycles
        cnt_q  <= CNT_W'(`WB_LSU_LATENCY - 2);
      end else if (finish) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Memory access happens on the completion edge
  always_ff @(posedge clk) begin
    if (finish && lsu_valid_i) begin
      if (lsu_we_i) begin
        mem_q[word_idx] <= lsu_wdata_i;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign lsu_valid_o = done_q;
  assign lsu_ready_o = !busy_q;
  assign lsu_rdata_o = rdata_q;

  // Only whole-word accesses are supported
  a_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    lsu_valid_i |-> (lsu_addr_i[1:0] == 2'b00))
    else $error("wb_lsu misaligned address %h", lsu_addr_i);

  // Request must stay put while the access is in flight
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    busy_q |-> (lsu_valid_i && $stable(lsu_addr_i) && $stable(lsu_we_i)))
    else $error("wb_lsu request changed during access");

endmodule

`default_nettype wire

/* logic/wb_mem_pkg.sv */
/*
  Types for the memory side and the coprocessor result path
  Function codes 2 and 3 are illegal and complete with exc set
*/
`default_nettype none

`include "wb_pipe_macros.svh"

package wb_mem_pkg;

  // MPU check result for the current access
  typedef enum logic [0:0] {
    MPU_OK       = 1'b0,
    MPU_RE_FAULT = 1'b1
  } mpu_status_e;

  // Coprocessor function select
  typedef enum logic [1:0] {
    XIF_BSWAP  = 2'd0,
    XIF_POPCNT = 2'd1
  } xif_funct_e;

  // Result returned over the offload interface
  typedef struct packed {
    logic [`WB_XLEN-1:0] data;
    logic                exc;   // Illegal function
  } xif_result_t;

endpackage

`default_nettype wire

/* logic/wb_pipe_pkg.sv */
/*
  Types for the pipeline side of write-back
  The EX/WB bundle is held stable by the environment until it leaves
*/
`default_nettype none

`include "wb_pipe_macros.svh"

package wb_pipe_pkg;

  // Register file index
  typedef logic [4:0] rf_addr_t;

  ////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////

  typedef struct packed {
    logic                instr_valid;
    // ALU result path
    logic                rf_we;
    rf_addr_t            rf_waddr;
    logic [`WB_XLEN-1:0] rf_wdata;
    // Load/store request
    logic                lsu_en;
    logic                lsu_we;      // Set for a store
    logic [`WB_XLEN-1:0] lsu_addr;
    logic [`WB_XLEN-1:0] lsu_wdata;
    // Offload to the coprocessor
    logic                xif_en;
    logic [1:0]          xif_funct;
    logic [`WB_XLEN-1:0] xif_operand;
  } ex_wb_pipe_t;

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  typedef struct packed {
    logic kill_wb;  // Drop the instruction in WB
    logic halt_wb;  // Hold it without retiring
  } ctrl_fsm_t;

endpackage

`default_nettype wire

/* logic/wb_pipe_macros.svh */
/*
  Sizing constants shared by the write-back subsystem
  WB_LSU_LATENCY must be 2 or more, and WB_MPU_LIMIT must lie inside the data memory
*/
`ifndef WB_PIPE_MACROS_SVH
`define WB_PIPE_MACROS_SVH

// Data path width in bits
`define WB_XLEN 32

// Data memory depth in 32-bit words
`define WB_MEM_WORDS 64

// First byte address outside the permitted MPU region
`define WB_MPU_LIMIT 128

// Cycles from request to completion in the LSU
`define WB_LSU_LATENCY 2

// Longest coprocessor latency in cycles
`define WB_COPRO_MAX_LAT 4

`endif
